// File: rtl/mips_pkg.sv
package mips_pkg;

  localparam int NB_WORD     = 32;
  localparam int NB_REG_ADDR = 5;
  localparam int NB_IMM      = 16;
  localparam int NB_CTRL     = 6;
  localparam int NB_SIZE     = 3;

  // primary opcode, instruction bits 31..26
  typedef enum logic [NB_CTRL-1:0] {
    OP_RTYPE = 6'h00,   // SPECIAL, decoded by funct
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_SLTI  = 6'h0a,
    OP_ANDI  = 6'h0c,
    OP_ORI   = 6'h0d,
    OP_XORI  = 6'h0e,
    OP_LUI   = 6'h0f,
    OP_LB    = 6'h20,
    OP_LW    = 6'h23,
    OP_SB    = 6'h28,
    OP_SW    = 6'h2b
  } opcode_e;

  // funct field for SPECIAL, bits 5..0
  typedef enum logic [NB_CTRL-1:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_NOR  = 6'h27,
    FN_SLT  = 6'h2a
  } funct_e;

  typedef enum logic [1:0] {
    EXT_SIGN  = 2'b00,
    EXT_ZERO  = 2'b01,
    EXT_UPPER = 2'b10   // lui
  } ext_mode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL
  } alu_op_e;

  // one bit per access size, half-word slot left free
  typedef enum logic [NB_SIZE-1:0] {
    SIZE_NONE = 3'b000,
    SIZE_BYTE = 3'b001,
    SIZE_WORD = 3'b100
  } word_size_e;

endpackage

// File: rtl/mips_control.sv
`timescale 1ns/1ps

module mips_control (
  input  mips_pkg::opcode_e    i_opcode,
  input  mips_pkg::funct_e     i_funct,
  output mips_pkg::alu_op_e    o_alu_op,
  output mips_pkg::ext_mode_e  o_ext_mode,
  output logic                 o_reg_dst,     // 1 selects rd
  output logic                 o_wb_enable,
  output logic                 o_alu_src,
  output logic                 o_mem_read,
  output logic                 o_mem_write,
  output logic                 o_reg_write,
  output logic                 o_branch,
  output logic                 o_jump,
  output mips_pkg::word_size_e o_word_size
);

  import mips_pkg::*;

  always_comb begin
    o_alu_op    = ALU_ADD;
    o_ext_mode  = EXT_SIGN;
    o_reg_dst   = 1'b0;
    o_wb_enable = 1'b0;
    o_alu_src   = 1'b0;
    o_mem_read  = 1'b0;
    o_mem_write = 1'b0;
    o_reg_write = 1'b0;
    o_branch    = 1'b0;
    o_jump      = 1'b0;
    o_word_size = SIZE_NONE;

    case (i_opcode)
      OP_RTYPE: begin
        o_reg_dst   = 1'b1;
        o_wb_enable = 1'b1;
        o_reg_write = 1'b1;
        case (i_funct)
          FN_ADDU: o_alu_op = ALU_ADD;
          FN_SUBU: o_alu_op = ALU_SUB;
          FN_AND:  o_alu_op = ALU_AND;
          FN_OR:   o_alu_op = ALU_OR;
          FN_XOR:  o_alu_op = ALU_XOR;
          FN_NOR:  o_alu_op = ALU_NOR;
          FN_SLT:  o_alu_op = ALU_SLT;
          FN_SLL:  o_alu_op = ALU_SLL;
          FN_SRL:  o_alu_op = ALU_SRL;
          default: begin       // unknown funct, nothing asserted
            o_reg_dst   = 1'b0;
            o_wb_enable = 1'b0;
            o_reg_write = 1'b0;
          end
        endcase
      end
      OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        o_alu_src   = 1'b1;
        o_wb_enable = 1'b1;
        o_reg_write = 1'b1;
        case (i_opcode)
          OP_SLTI: o_alu_op = ALU_SLT;
          OP_ANDI: o_alu_op = ALU_AND;
          OP_ORI:  o_alu_op = ALU_OR;
          OP_XORI: o_alu_op = ALU_XOR;
          default: o_alu_op = ALU_ADD;   // addiu, lui (rs is r0 for lui)
        endcase
        if (i_opcode inside {OP_ANDI, OP_ORI, OP_XORI})
          o_ext_mode = EXT_ZERO;
        else if (i_opcode == OP_LUI)
          o_ext_mode = EXT_UPPER;
      end
      OP_LB, OP_LW: begin
        o_alu_src   = 1'b1;
        o_mem_read  = 1'b1;
        o_reg_write = 1'b1;     // flag only, no load write-back here
        o_word_size = (i_opcode == OP_LB) ? SIZE_BYTE : SIZE_WORD;
      end
      OP_SB, OP_SW: begin
        o_alu_src   = 1'b1;
        o_mem_write = 1'b1;
        o_word_size = (i_opcode == OP_SB) ? SIZE_BYTE : SIZE_WORD;
      end
      OP_BEQ, OP_BNE: begin
        o_branch = 1'b1;
        o_alu_op = ALU_SUB;     // compare rs and rt
      end
      OP_J: begin
        o_jump = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: rtl/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile #(
  parameter int NB   = mips_pkg::NB_WORD,
  parameter int REGS = mips_pkg::NB_REG_ADDR
) (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_step,
  input  logic            i_wb_enable,
  input  logic [REGS-1:0] i_addr_rs,
  input  logic [REGS-1:0] i_addr_rt,
  input  logic [REGS-1:0] i_addr_wr,
  input  logic [NB-1:0]   i_wr_data,
  input  logic [REGS-1:0] i_debug_reg,
  output logic [NB-1:0]   o_data_rs,
  output logic [NB-1:0]   o_data_rt,
  output logic [NB-1:0]   o_debug_data
);

  localparam int DEPTH = 2**REGS;

  logic [NB-1:0] regs [DEPTH];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        regs[i] <= '0;
      end
    end else if (i_step && i_wb_enable && (i_addr_wr != '0)) begin  // r0 discarded
      regs[i_addr_wr] <= i_wr_data;
    end
  end

  always_comb begin
    o_data_rs    = regs[i_addr_rs];     // r0 cleared by reset and never written
    o_data_rt    = regs[i_addr_rt];
    o_debug_data = regs[i_debug_reg];
  end

endmodule

// File: rtl/mips_imm_extend.sv
`timescale 1ns/1ps

module mips_imm_extend #(
  parameter int NB_IN = mips_pkg::NB_IMM,
  parameter int NB    = mips_pkg::NB_WORD
) (
  input  logic [NB_IN-1:0]  i_immediate,
  input  mips_pkg::ext_mode_e i_ext_mode,
  output logic [NB-1:0]     o_extended
);

  import mips_pkg::*;

  always_comb begin
    case (i_ext_mode)
      EXT_ZERO:  o_extended = {{(NB-NB_IN){1'b0}}, i_immediate};
      EXT_UPPER: o_extended = {i_immediate, {(NB-NB_IN){1'b0}}};   // lui
      default:   o_extended = {{(NB-NB_IN){i_immediate[NB_IN-1]}}, i_immediate};
    endcase
  end

endmodule

// File: rtl/mips_alu.sv
`timescale 1ns/1ps

module mips_alu #(
  parameter int NB = mips_pkg::NB_WORD
) (
  input  mips_pkg::alu_op_e      i_op,
  input  logic [NB-1:0]          i_a,
  input  logic [NB-1:0]          i_b,
  input  logic [$clog2(NB)-1:0]  i_shamt,
  output logic [NB-1:0]          o_result
);

  import mips_pkg::*;

  logic lt_signed;

  assign lt_signed = $signed(i_a) < $signed(i_b);

  always_comb begin
    case (i_op)
      ALU_ADD: o_result = i_a + i_b;             // wraps, no overflow trap
      ALU_SUB: o_result = i_a - i_b;
      ALU_AND: o_result = i_a & i_b;
      ALU_OR:  o_result = i_a | i_b;
      ALU_XOR: o_result = i_a ^ i_b;
      ALU_NOR: o_result = ~(i_a | i_b);
      ALU_SLT: o_result = {{(NB-1){1'b0}}, lt_signed};
      ALU_SLL: o_result = i_b << i_shamt;        // shifts act on rt
      ALU_SRL: o_result = i_b >> i_shamt;
      default: o_result = '0;
    endcase
  end

endmodule

// File: rtl/mips_decode_step.sv
`timescale 1ns/1ps

module mips_decode_step #(
  parameter int NB   = mips_pkg::NB_WORD,
  parameter int REGS = mips_pkg::NB_REG_ADDR
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_step,
  input  logic [NB-1:0]        i_instruction,
  input  logic [REGS-1:0]      i_debug_reg,
  output logic [NB-1:0]        o_data_a,
  output logic [NB-1:0]        o_data_b,
  output logic [NB-1:0]        o_debug_data,
  output logic [NB-1:0]        o_extension_result,
  output logic [NB-1:0]        o_alu_result,
  output logic                 o_alu_src,
  output logic                 o_mem_read,
  output logic                 o_mem_write,
  output logic                 o_reg_write,
  output logic                 o_branch,
  output logic                 o_jump,
  output mips_pkg::word_size_e o_word_size
);

  import mips_pkg::*;

  localparam int NB_SHAMT = $clog2(NB);

  opcode_e              w_opcode;
  funct_e               w_funct;
  logic [REGS-1:0]      w_rs;
  logic [REGS-1:0]      w_rt;
  logic [REGS-1:0]      w_rd;
  logic [REGS-1:0]      w_addr_wr;
  logic [NB_SHAMT-1:0]  w_shamt;
  logic [NB_IMM-1:0]    w_immediate;
  logic [NB-1:0]        w_alu_b;
  alu_op_e              w_alu_op;
  ext_mode_e            w_ext_mode;
  logic                 w_reg_dst;
  logic                 w_wb_enable;

  assign w_opcode    = opcode_e'(i_instruction[NB-1 -: NB_CTRL]);
  assign w_rs        = i_instruction[NB_IMM+REGS +: REGS];   // [25:21]
  assign w_rt        = i_instruction[NB_IMM +: REGS];        // [20:16]
  assign w_rd        = i_instruction[NB_IMM-REGS +: REGS];   // [15:11]
  assign w_shamt     = i_instruction[NB_CTRL +: NB_SHAMT];   // [10:6]
  assign w_funct     = funct_e'(i_instruction[NB_CTRL-1:0]);
  assign w_immediate = i_instruction[NB_IMM-1:0];

  assign w_addr_wr = w_reg_dst ? w_rd : w_rt;
  assign w_alu_b   = o_alu_src ? o_extension_result : o_data_b;

  mips_control u_control (
    .i_opcode    (w_opcode),
    .i_funct     (w_funct),
    .o_alu_op    (w_alu_op),
    .o_ext_mode  (w_ext_mode),
    .o_reg_dst   (w_reg_dst),
    .o_wb_enable (w_wb_enable),
    .o_alu_src   (o_alu_src),
    .o_mem_read  (o_mem_read),
    .o_mem_write (o_mem_write),
    .o_reg_write (o_reg_write),
    .o_branch    (o_branch),
    .o_jump      (o_jump),
    .o_word_size (o_word_size)
  );

  mips_regfile #(
    .NB   (NB),
    .REGS (REGS)
  ) u_regfile (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_step       (i_step),
    .i_wb_enable  (w_wb_enable),
    .i_addr_rs    (w_rs),
    .i_addr_rt    (w_rt),
    .i_addr_wr    (w_addr_wr),
    .i_wr_data    (o_alu_result),   // write-back path
    .i_debug_reg  (i_debug_reg),
    .o_data_rs    (o_data_a),
    .o_data_rt    (o_data_b),
    .o_debug_data (o_debug_data)
  );

  mips_imm_extend #(
    .NB_IN (NB_IMM),
    .NB    (NB)
  ) u_imm_extend (
    .i_immediate (w_immediate),
    .i_ext_mode  (w_ext_mode),
    .o_extended  (o_extension_result)
  );

  mips_alu #(
    .NB (NB)
  ) u_alu (
    .i_op     (w_alu_op),
    .i_a      (o_data_a),
    .i_b      (w_alu_b),
    .i_shamt  (w_shamt),
    .o_result (o_alu_result)
  );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;   // 20 ns period
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #2 o_rst_n = 1'b1;                    // released off the edge
  end

endmodule

// File: test/mips_decode_step_asserts.sv
`timescale 1ns/1ps

module mips_decode_step_asserts #(
  parameter int NB   = mips_pkg::NB_WORD,
  parameter int REGS = mips_pkg::NB_REG_ADDR
) (
  input logic            i_clk,
  input logic            i_rst_n,
  input logic            i_step,
  input logic [REGS-1:0] i_debug_reg,
  input logic [NB-1:0]   o_debug_data,
  input logic            o_mem_read,
  input logic            o_mem_write
);

  int fail_count = 0;

  r0_reads_zero: assert property (@(posedge i_clk)
    (i_rst_n && (i_debug_reg == '0)) |-> (o_debug_data == '0))
    else begin
      fail_count++;
      $error("debug port gave nonzero data for register 0");
    end

  mem_flags_exclusive: assert property (@(posedge i_clk)
    !(o_mem_read && o_mem_write))
    else begin
      fail_count++;
      $error("mem read and mem write high together");
    end

  // no step means no write so the same register reads the same
  debug_stable_no_step: assert property (@(posedge i_clk)
    (i_rst_n && !i_step) |=> ($stable(i_debug_reg) -> $stable(o_debug_data)))
    else begin
      fail_count++;
      $error("register changed without a step");
    end

endmodule

// File: test/mips_decode_step_tb.sv
`timescale 1ns/1ps

module mips_decode_step_tb;

  import mips_pkg::*;

  localparam string STIM_FILE = "test/mips_decode_step_stimulus.txt";

  logic                   clk;
  logic                   rst_n;
  logic                   step;
  logic [NB_WORD-1:0]     instruction;
  logic [NB_REG_ADDR-1:0] debug_reg;
  logic [NB_WORD-1:0]     data_a;
  logic [NB_WORD-1:0]     data_b;
  logic [NB_WORD-1:0]     debug_data;
  logic [NB_WORD-1:0]     ext_result;
  logic [NB_WORD-1:0]     alu_result;
  logic                   alu_src;
  logic                   mem_read;
  logic                   mem_write;
  logic                   reg_write;
  logic                   branch;
  logic                   jump;
  word_size_e             word_size;

  logic [NB_WORD-1:0] v_instr [$];
  logic [NB_WORD-1:0] v_step [$];
  logic [NB_WORD-1:0] v_dbg [$];
  logic [NB_WORD-1:0] v_alu [$];
  logic [NB_WORD-1:0] v_ext [$];
  logic [NB_WORD-1:0] v_data [$];
  logic [NB_WORD-1:0] v_flags [$];   // {word_size, alu_src, rd, wr, reg_wr, br, j}
  logic [NB_WORD-1:0] model_regs [2**NB_REG_ADDR];   // expected register contents
  int cycle_count = 0;
  int cycle_limit = 20;
  int vec_num = 0;

  tb_clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(2)) u_clock (.o_clk(clk), .o_rst_n(rst_n));

  mips_decode_step #(.NB(NB_WORD), .REGS(NB_REG_ADDR)) UUT (
    .i_clk(clk), .i_rst_n(rst_n), .i_step(step), .i_instruction(instruction),
    .i_debug_reg(debug_reg), .o_data_a(data_a), .o_data_b(data_b),
    .o_debug_data(debug_data), .o_extension_result(ext_result),
    .o_alu_result(alu_result), .o_alu_src(alu_src), .o_mem_read(mem_read),
    .o_mem_write(mem_write), .o_reg_write(reg_write), .o_branch(branch),
    .o_jump(jump), .o_word_size(word_size)
  );

  bind mips_decode_step mips_decode_step_asserts #(.NB(NB), .REGS(REGS)) u_asserts (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_step(i_step), .i_debug_reg(i_debug_reg),
    .o_debug_data(o_debug_data), .o_mem_read(o_mem_read), .o_mem_write(o_mem_write)
  );

  task automatic load_vectors();
    int fd;
    int n;
    string line;
    logic [NB_WORD-1:0] col [7];
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      $display("Test FAILED");
      $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#") continue;   // column header
      n = $sscanf(line, "%h %h %h %h %h %h %h",
                  col[0], col[1], col[2], col[3], col[4], col[5], col[6]);
      if (n == 7) begin
        v_instr.push_back(col[0]);
        v_step.push_back(col[1]);
        v_dbg.push_back(col[2]);
        v_alu.push_back(col[3]);
        v_ext.push_back(col[4]);
        v_data.push_back(col[5]);
        v_flags.push_back(col[6]);
      end else if (n > 0) begin
        $display("Stimulus line has %0d fields instead of 7: %s", n, line);
        $display("Test FAILED");
        $fatal(1, "bad stimulus line");
      end
    end
    $fclose(fd);
  endtask

  // rd for SPECIAL, rt for the immediate forms, loads write nothing
  task automatic model_write_back(input int idx);
    logic [NB_REG_ADDR-1:0] dest;
    if (v_step[idx][0] && v_flags[idx][2] && !v_flags[idx][4]) begin
      dest = (v_instr[idx][31:26] == 6'h00) ? v_instr[idx][15:11] : v_instr[idx][20:16];
      if (dest != '0) begin
        model_regs[dest] = v_alu[idx];
      end
    end
  endtask

  task automatic check_word(input string name, input logic [NB_WORD-1:0] got,
                            input logic [NB_WORD-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s (vector %0d): got 0x%h, expected 0x%h", name, vec_num, got, exp);
      $display("Test FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_flags(input string name, input logic [5:0] got, input logic [5:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s (vector %0d): got 0x%h, expected 0x%h", name, vec_num, got, exp);
      $display("Test FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_word_size(input string name, input word_size_e got,
                                 input word_size_e exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s (vector %0d): got 0x%h, expected 0x%h", name, vec_num, got, exp);
      $display("Test FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the vectors did not finish", cycle_count);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end else if (UUT.u_asserts.fail_count != 0) begin
      $display("A bound assertion failed, see the error above");
      $display("Test FAILED");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    step        = 1'b0;
    instruction = '0;     // nop during reset
    debug_reg   = '0;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    load_vectors();
    cycle_limit = 4 * v_instr.size() + 20;
    wait (rst_n === 1'b1);
    for (vec_num = 0; vec_num < v_instr.size(); vec_num++) begin
      @(posedge clk);
      #2;
      instruction = v_instr[vec_num];
      step        = v_step[vec_num][0];
      debug_reg   = v_dbg[vec_num][NB_REG_ADDR-1:0];
      #15;                // settled, before the next edge
      check_word("o_data_a", data_a, model_regs[v_instr[vec_num][25:21]]);
      check_word("o_data_b", data_b, model_regs[v_instr[vec_num][20:16]]);
      check_word("o_alu_result", alu_result, v_alu[vec_num]);
      check_word("o_extension_result", ext_result, v_ext[vec_num]);
      check_word("o_debug_data", debug_data, v_data[vec_num]);
      check_flags("control flags", {alu_src, mem_read, mem_write, reg_write, branch, jump},
                  v_flags[vec_num][5:0]);
      check_word_size("o_word_size", word_size, word_size_e'(v_flags[vec_num][8:6]));
      model_write_back(vec_num);
    end
    @(posedge clk);
    #2;
    step = 1'b0;
    if (v_instr.size() > 0 && UUT.u_asserts.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("No vectors applied or an assertion failed");
      $display("Test FAILED");
      $fatal(1, "run failed");
    end
  end

endmodule

// File: test/mips_decode_step_stimulus.txt
# instr step dbg_reg alu_result ext_result dbg_data flags, all hex, dbg_data is before the step
# flags = {word_size[2:0], alu_src, mem_read, mem_write, reg_write, branch, jump}
00000000 0 01 00000000 00000000 00000000 004
00000000 0 1f 00000000 00000000 00000000 004
24018001 1 01 ffff8001 ffff8001 00000000 024
342200f0 1 01 ffff80f1 000000f0 ffff8001 024
3c031234 1 02 12340000 12340000 ffff80f1 024
3864ffff 1 03 1234ffff 0000ffff 12340000 024
00642821 1 04 2468ffff 00002821 1234ffff 004
00223023 1 05 ffffff10 00003023 2468ffff 004
00443824 1 06 123480f1 00003824 ffffff10 004
00614027 1 07 00007ffe 00004027 123480f1 004
0026482a 1 08 00000001 0000482a 00007ffe 004
00045100 1 09 234ffff0 00005100 00000001 004
00015a02 1 0a 00ffff80 00005a02 234ffff0 004
240b0005 0 0b 00000005 00000005 00ffff80 024
24400010 1 0b ffff8101 00000010 00ffff80 024
8c6c0008 1 00 12340008 00000008 00000000 134
a044fffc 1 0c ffff80ed fffffffc 00000000 068
10220003 1 04 ffffff10 00000003 1234ffff 002
08000040 1 02 00000000 00000040 ffff80f1 001
00000000 0 01 00000000 00000000 ffff8001 004

// File: mips_decode_step.f
rtl/mips_pkg.sv
rtl/mips_control.sv
rtl/mips_regfile.sv
rtl/mips_imm_extend.sv
rtl/mips_alu.sv
rtl/mips_decode_step.sv
test/tb_clock_gen.sv
test/mips_decode_step_asserts.sv
test/mips_decode_step_tb.sv
